//--- all.f
hdl/rou_pkg.sv
hdl/rou_uop_queue.sv
hdl/rou_rename_table.sv
hdl/rou_operand_sel.sv
hdl/rou_rob.sv
hdl/rou_top.sv
sim/rou_checker.sv
sim/rou_tb.sv

//--- hdl/rou_operand_sel.sv
`timescale 1ns/1ps
`default_nettype none

module rou_operand_sel (
  input  wire rou_pkg::rou_uop_t uop_i,
  input  wire logic              src1_busy_i,
  input  wire rou_pkg::rob_tag_t src1_tag_i,
  input  wire logic              src2_busy_i,
  input  wire rou_pkg::rob_tag_t src2_tag_i,
  input  wire logic              rob1_done_i,
  input  wire rou_pkg::word_t    rob1_value_i,
  input  wire logic              rob2_done_i,
  input  wire rou_pkg::word_t    rob2_value_i,
  input  wire rou_pkg::word_t    reg_src1_i,
  input  wire rou_pkg::word_t    reg_src2_i,
  input  wire rou_pkg::rou_wb_t  wb_i,
  input  wire rou_pkg::rob_tag_t dest_i,
  output rou_pkg::rou_issue_t    issue_o,
  output rou_pkg::reg_idx_t      reg_rs1_o,
  output rou_pkg::reg_idx_t      reg_rs2_o
);
  import rou_pkg::*;

  typedef struct packed {
    word_t    value;
    rob_tag_t wait_tag;
  } operand_t;

  operand_t opnd1;
  operand_t opnd2;

  function automatic operand_t pick(input reg_idx_t idx, input word_t imm,
                                    input logic busy, input rob_tag_t tag,
                                    input logic rob_done, input word_t rob_value,
                                    input word_t reg_value, input rou_wb_t wb);
    operand_t res;
    res = '0;
    if (idx == '0) begin
      res.value = imm;
    end else if (!busy) begin
      res.value = reg_value;
    end else if (rob_done) begin
      res.value = rob_value;
    end else if (wb.valid && (wb.dest == tag)) begin
      // Producer finishing this very cycle
      res.value = wb.result;
    end else begin
      res.wait_tag = tag;
    end
    return res;
  endfunction

  assign reg_rs1_o = uop_i.rs1;
  assign reg_rs2_o = uop_i.rs2;

  assign opnd1 = pick(uop_i.rs1, uop_i.imm_op1, src1_busy_i, src1_tag_i,
                      rob1_done_i, rob1_value_i, reg_src1_i, wb_i);
  assign opnd2 = pick(uop_i.rs2, uop_i.imm_op2, src2_busy_i, src2_tag_i,
                      rob2_done_i, rob2_value_i, reg_src2_i, wb_i);

  always_comb begin
    issue_o.op1      = opnd1.value;
    issue_o.op2      = opnd2.value;
    issue_o.qj       = opnd1.wait_tag;
    issue_o.qk       = opnd2.wait_tag;
    issue_o.dest     = dest_i;
    issue_o.rd       = uop_i.rd;
    issue_o.alu      = uop_i.alu;
    issue_o.is_store = uop_i.is_store;
    issue_o.pc       = uop_i.pc;
  end

endmodule

`default_nettype wire

//--- hdl/rou_pkg.sv
`default_nettype none

package rou_pkg;

  localparam int XLEN    = 32;
  localparam int REG_NUM = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [4:0]      alu_t;
  // ROB index plus one, zero means ready
  typedef logic [3:0]      rob_tag_t;

  typedef enum logic [1:0] {
    CM = 2'b00,
    WB = 2'b01,
    EX = 2'b10
  } rob_state_e;

  typedef struct packed {
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm_op1;
    word_t    imm_op2;
    alu_t     alu;
    logic     is_store;
    logic     trap;
    word_t    pc;
    word_t    pnpc;
  } rou_uop_t;

  typedef struct packed {
    word_t    op1;
    word_t    op2;
    rob_tag_t qj;
    rob_tag_t qk;
    rob_tag_t dest;
    reg_idx_t rd;
    alu_t     alu;
    logic     is_store;
    word_t    pc;
  } rou_issue_t;

  typedef struct packed {
    logic     valid;
    rob_tag_t dest;
    word_t    result;
    word_t    npc;
    word_t    sq_waddr;
    word_t    sq_wdata;
  } rou_wb_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    wdata;
    word_t    pc;
    word_t    npc;
    logic     is_store;
    word_t    sq_waddr;
    word_t    sq_wdata;
    logic     flush;
  } rou_retire_t;

endpackage

`default_nettype wire

//--- hdl/rou_rename_table.sv
`timescale 1ns/1ps
`default_nettype none

module rou_rename_table (
  input  wire logic              clock,
  input  wire logic              rst_n_i,
  input  wire logic              flush_i,
  input  wire logic              dispatch_i,
  input  wire rou_pkg::reg_idx_t disp_rd_i,
  input  wire rou_pkg::rob_tag_t disp_tag_i,
  input  wire logic              retire_i,
  input  wire rou_pkg::reg_idx_t ret_rd_i,
  input  wire rou_pkg::rob_tag_t ret_tag_i,
  input  wire rou_pkg::reg_idx_t rs1_i,
  input  wire rou_pkg::reg_idx_t rs2_i,
  output logic                   src1_busy_o,
  output rou_pkg::rob_tag_t      src1_tag_o,
  output logic                   src2_busy_o,
  output rou_pkg::rob_tag_t      src2_tag_o
);
  import rou_pkg::*;

  logic [REG_NUM-1:0] busy_q;
  rob_tag_t           tag_q [REG_NUM];
  logic               set_en;
  logic               clr_en;

  // x0 is hardwired, never renamed
  assign set_en = dispatch_i && (disp_rd_i != '0);

  // Only the newest producer may release the register
  assign clr_en = retire_i && busy_q[ret_rd_i] && (tag_q[ret_rd_i] == ret_tag_i)
                  && !(dispatch_i && (disp_rd_i == ret_rd_i));

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= '0;
    end else if (flush_i) begin
      busy_q <= '0;
    end else begin
      if (clr_en) begin
        busy_q[ret_rd_i] <= 1'b0;
      end
      if (set_en) begin
        busy_q[disp_rd_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (set_en) begin
      tag_q[disp_rd_i] <= disp_tag_i;
    end
  end

  assign src1_busy_o = busy_q[rs1_i];
  assign src1_tag_o  = tag_q[rs1_i];
  assign src2_busy_o = busy_q[rs2_i];
  assign src2_tag_o  = tag_q[rs2_i];

endmodule

`default_nettype wire

//--- hdl/rou_rob.sv
`timescale 1ns/1ps
`default_nettype none

module rou_rob #(
  parameter int unsigned ROB_SIZE = 8
) (
  input  wire logic              clock,
  input  wire logic              rst_n_i,
  input  wire logic              flush_i,
  input  wire logic              dispatch_i,
  input  wire rou_pkg::rou_uop_t uop_i,
  input  wire rou_pkg::rou_wb_t  wb_i,
  input  wire logic              sq_ready_i,
  input  wire rou_pkg::rob_tag_t look1_tag_i,
  input  wire rou_pkg::rob_tag_t look2_tag_i,
  output logic                   free_o,
  output rou_pkg::rob_tag_t      alloc_tag_o,
  output logic                   look1_done_o,
  output rou_pkg::word_t         look1_value_o,
  output logic                   look2_done_o,
  output rou_pkg::word_t         look2_value_o,
  output rou_pkg::rou_retire_t   retire_o
);
  import rou_pkg::*;

  localparam int PW = $clog2(ROB_SIZE);

  logic [PW-1:0] head_q;
  logic [PW-1:0] tail_q;
  rob_state_e    state_q [ROB_SIZE];

  reg_idx_t rd_q       [ROB_SIZE];
  word_t    pc_q       [ROB_SIZE];
  word_t    pnpc_q     [ROB_SIZE];
  logic     store_q    [ROB_SIZE];
  logic     trap_q     [ROB_SIZE];
  word_t    value_q    [ROB_SIZE];
  word_t    npc_q      [ROB_SIZE];
  word_t    sq_waddr_q [ROB_SIZE];
  word_t    sq_wdata_q [ROB_SIZE];

  logic [PW-1:0] wb_idx;
  logic [PW-1:0] look1_idx;
  logic [PW-1:0] look2_idx;
  logic          head_done;
  logic          retire;

  assign free_o      = (state_q[tail_q] == CM);
  assign alloc_tag_o = rob_tag_t'(tail_q) + rob_tag_t'(1);

  // Tags carry a +1 offset over the entry index
  assign wb_idx    = PW'(wb_i.dest - rob_tag_t'(1));
  assign look1_idx = PW'(look1_tag_i - rob_tag_t'(1));
  assign look2_idx = PW'(look2_tag_i - rob_tag_t'(1));

  assign look1_done_o  = (state_q[look1_idx] == WB);
  assign look1_value_o = value_q[look1_idx];
  assign look2_done_o  = (state_q[look2_idx] == WB);
  assign look2_value_o = value_q[look2_idx];

  // Stores also need room in the store queue
  assign head_done = (state_q[head_q] == WB);
  assign retire    = head_done && (!store_q[head_q] || sq_ready_i) && !flush_i;

  always_comb begin
    retire_o.valid    = retire;
    retire_o.rd       = rd_q[head_q];
    retire_o.wdata    = value_q[head_q];
    retire_o.pc       = pc_q[head_q];
    retire_o.npc      = npc_q[head_q];
    retire_o.is_store = store_q[head_q];
    retire_o.sq_waddr = sq_waddr_q[head_q];
    retire_o.sq_wdata = sq_wdata_q[head_q];
    // Mispredicted next PC or trap
    retire_o.flush    = retire && ((npc_q[head_q] != pnpc_q[head_q]) || trap_q[head_q]);
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q <= '0;
      tail_q <= '0;
      for (int i = 0; i < ROB_SIZE; i++) begin
        state_q[i] <= CM;
      end
    end else if (flush_i) begin
      head_q <= '0;
      tail_q <= '0;
      for (int i = 0; i < ROB_SIZE; i++) begin
        state_q[i] <= CM;
      end
    end else begin
      if (dispatch_i) begin
        state_q[tail_q] <= EX;
        tail_q          <= tail_q + 1'b1;
      end
      if (wb_i.valid) begin
        state_q[wb_idx] <= WB;
      end
      if (retire) begin
        state_q[head_q] <= CM;
        head_q          <= head_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (dispatch_i) begin
      rd_q[tail_q]    <= uop_i.rd;
      pc_q[tail_q]    <= uop_i.pc;
      pnpc_q[tail_q]  <= uop_i.pnpc;
      store_q[tail_q] <= uop_i.is_store;
      trap_q[tail_q]  <= uop_i.trap;
    end
    if (wb_i.valid) begin
      value_q[wb_idx]    <= wb_i.result;
      npc_q[wb_idx]      <= wb_i.npc;
      sq_waddr_q[wb_idx] <= wb_i.sq_waddr;
      sq_wdata_q[wb_idx] <= wb_i.sq_wdata;
    end
  end

endmodule

`default_nettype wire

//--- hdl/rou_top.sv
`timescale 1ns/1ps
`default_nettype none

module rou_top #(
  parameter int unsigned IQ_SIZE  = 4,
  parameter int unsigned ROB_SIZE = 8
) (
  input  wire logic              clock,
  input  wire logic              rst_n_i,
  input  wire logic              flush_i,
  input  wire logic              prev_valid_i,
  input  wire rou_pkg::rou_uop_t uop_i,
  input  wire logic              next_ready_i,
  input  wire rou_pkg::word_t    reg_src1_i,
  input  wire rou_pkg::word_t    reg_src2_i,
  input  wire rou_pkg::rou_wb_t  wb_i,
  input  wire logic              sq_ready_i,
  output logic                   out_ready_o,
  output logic                   out_valid_o,
  output rou_pkg::rou_issue_t    issue_o,
  output rou_pkg::reg_idx_t      reg_rs1_o,
  output rou_pkg::reg_idx_t      reg_rs2_o,
  output rou_pkg::rou_retire_t   retire_o
);
  import rou_pkg::*;

  localparam int RPW = $clog2(ROB_SIZE);

  logic           tail_valid;
  rou_uop_t       tail_uop;
  logic           rob_free;
  rob_tag_t       alloc_tag;
  logic           dispatch;
  logic           src1_busy;
  logic           src2_busy;
  rob_tag_t       src1_tag;
  rob_tag_t       src2_tag;
  logic           rob1_done;
  logic           rob2_done;
  word_t          rob1_value;
  word_t          rob2_value;
  logic [RPW-1:0] ret_idx_q;
  rob_tag_t       ret_tag;

  assign out_valid_o = tail_valid && rob_free;
  assign dispatch    = out_valid_o && next_ready_i;

  // Tracks the ROB head to name the retiring producer
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ret_idx_q <= '0;
    end else if (flush_i) begin
      ret_idx_q <= '0;
    end else if (retire_o.valid) begin
      ret_idx_q <= ret_idx_q + 1'b1;
    end
  end

  assign ret_tag = rob_tag_t'(ret_idx_q) + rob_tag_t'(1);

  rou_uop_queue #(.IQ_SIZE(IQ_SIZE)) u_queue (
    .clock(clock), .rst_n_i(rst_n_i), .flush_i(flush_i),
    .prev_valid_i(prev_valid_i), .uop_i(uop_i), .dispatch_i(dispatch),
    .out_ready_o(out_ready_o), .tail_valid_o(tail_valid), .tail_uop_o(tail_uop)
  );

  rou_rename_table u_rename (
    .clock(clock), .rst_n_i(rst_n_i), .flush_i(flush_i),
    .dispatch_i(dispatch), .disp_rd_i(tail_uop.rd), .disp_tag_i(alloc_tag),
    .retire_i(retire_o.valid), .ret_rd_i(retire_o.rd), .ret_tag_i(ret_tag),
    .rs1_i(tail_uop.rs1), .rs2_i(tail_uop.rs2),
    .src1_busy_o(src1_busy), .src1_tag_o(src1_tag),
    .src2_busy_o(src2_busy), .src2_tag_o(src2_tag)
  );

  rou_operand_sel u_opsel (
    .uop_i(tail_uop),
    .src1_busy_i(src1_busy), .src1_tag_i(src1_tag),
    .src2_busy_i(src2_busy), .src2_tag_i(src2_tag),
    .rob1_done_i(rob1_done), .rob1_value_i(rob1_value),
    .rob2_done_i(rob2_done), .rob2_value_i(rob2_value),
    .reg_src1_i(reg_src1_i), .reg_src2_i(reg_src2_i),
    .wb_i(wb_i), .dest_i(alloc_tag),
    .issue_o(issue_o), .reg_rs1_o(reg_rs1_o), .reg_rs2_o(reg_rs2_o)
  );

  rou_rob #(.ROB_SIZE(ROB_SIZE)) u_rob (
    .clock(clock), .rst_n_i(rst_n_i), .flush_i(flush_i),
    .dispatch_i(dispatch), .uop_i(tail_uop), .wb_i(wb_i), .sq_ready_i(sq_ready_i),
    .look1_tag_i(src1_tag), .look2_tag_i(src2_tag),
    .free_o(rob_free), .alloc_tag_o(alloc_tag),
    .look1_done_o(rob1_done), .look1_value_o(rob1_value),
    .look2_done_o(rob2_done), .look2_value_o(rob2_value),
    .retire_o(retire_o)
  );

endmodule

`default_nettype wire

//--- hdl/rou_uop_queue.sv
`timescale 1ns/1ps
`default_nettype none

module rou_uop_queue #(
  parameter int unsigned IQ_SIZE = 4
) (
  input  wire logic              clock,
  input  wire logic              rst_n_i,
  input  wire logic              flush_i,
  input  wire logic              prev_valid_i,
  input  wire rou_pkg::rou_uop_t uop_i,
  input  wire logic              dispatch_i,
  output logic                   out_ready_o,
  output logic                   tail_valid_o,
  output rou_pkg::rou_uop_t      tail_uop_o
);
  import rou_pkg::*;

  localparam int PW = $clog2(IQ_SIZE);

  logic [PW-1:0]      head_q;
  logic [PW-1:0]      tail_q;
  logic [IQ_SIZE-1:0] valid_q;
  rou_uop_t           slot_q [IQ_SIZE];
  logic               capture;

  // Head slot still occupied means the ring is full
  assign out_ready_o  = !valid_q[head_q];
  assign capture      = prev_valid_i && !valid_q[head_q];

  assign tail_valid_o = valid_q[tail_q];
  assign tail_uop_o   = slot_q[tail_q];

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      valid_q <= '0;
    end else if (flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      valid_q <= '0;
    end else begin
      if (capture) begin
        head_q          <= head_q + 1'b1;
        valid_q[head_q] <= 1'b1;
      end
      // never the same slot as capture, tail is valid and head is not
      if (dispatch_i) begin
        tail_q          <= tail_q + 1'b1;
        valid_q[tail_q] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (capture) begin
      slot_q[head_q] <= uop_i;
    end
  end

endmodule

`default_nettype wire

//--- sim/rou_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rou_checker (
  input  wire logic                 clock,
  input  wire logic                 rst_n_i,
  input  wire logic                 flush_i,
  input  wire logic                 prev_valid_i,
  input  wire logic                 out_ready_i,
  input  wire rou_pkg::rou_uop_t    uop_i,
  input  wire logic [63:0]          name_i,
  input  wire rou_pkg::word_t       anpc_i,
  input  wire logic                 out_valid_i,
  input  wire logic                 next_ready_i,
  input  wire rou_pkg::rou_issue_t  issue_i,
  input  wire logic                 sq_ready_i,
  input  wire rou_pkg::rou_retire_t retire_i,
  output int                        errors_o,
  output int                        passed_o,
  output int                        retired_o
);
  import rou_pkg::*;

  localparam alu_t ALU_PASS = 5'd1;

  typedef struct packed {
    logic [63:0] name;
    rou_uop_t    uop;
    word_t       anpc;
    word_t       op1;
    word_t       op2;
    word_t       result;
    logic        bad;
  } expect_t;

  // In-order model where spec runs ahead at capture and arch follows retirement
  expect_t pend [$];
  word_t   arch [REG_NUM];
  word_t   spec [REG_NUM];
  int      disp_ptr;

  initial begin
    errors_o  = 0;
    passed_o  = 0;
    retired_o = 0;
    disp_ptr  = 0;
    for (int i = 0; i < REG_NUM; i++) begin
      arch[i] = i * 32'h0101_0101;
      spec[i] = arch[i];
    end
  end

  task automatic compare(input logic [63:0] name, input string field, input word_t exp,
                         input word_t act, inout logic bad);
    if (exp !== act) begin
      $display("Fail %s %s: expected %h, actual %h", name, field, exp, act);
      errors_o++;
      bad = 1'b1;
    end
  endtask

  task automatic capture_row();
    expect_t e;
    e.name   = name_i;
    e.uop    = uop_i;
    e.anpc   = anpc_i;
    e.bad    = 1'b0;
    e.op1    = (uop_i.rs1 == '0) ? uop_i.imm_op1 : spec[uop_i.rs1];
    e.op2    = (uop_i.rs2 == '0) ? uop_i.imm_op2 : spec[uop_i.rs2];
    e.result = (uop_i.alu == ALU_PASS) ? e.op1 : e.op1 + e.op2;
    if (uop_i.rd != '0 && !uop_i.is_store) begin
      spec[uop_i.rd] = e.result;
    end
    pend.push_back(e);
  endtask

  task automatic check_issue();
    expect_t e;
    logic    bad;
    if (disp_ptr >= pend.size()) begin
      $display("Dispatch seen with no captured micro-op waiting for it");
      errors_o++;
    end else begin
      e   = pend[disp_ptr];
      bad = e.bad;
      compare(e.name, "issue pc", e.uop.pc, issue_i.pc, bad);
      compare(e.name, "issue rd", {27'd0, e.uop.rd}, {27'd0, issue_i.rd}, bad);
      compare(e.name, "issue alu", {27'd0, e.uop.alu}, {27'd0, issue_i.alu}, bad);
      compare(e.name, "issue is_store", {31'd0, e.uop.is_store}, {31'd0, issue_i.is_store},
              bad);
      if (e.uop.rs1 == '0) begin
        compare(e.name, "qj", '0, {28'd0, issue_i.qj}, bad);
      end
      if (issue_i.qj == '0) begin
        compare(e.name, "op1", e.op1, issue_i.op1, bad);
      end
      if (e.uop.rs2 == '0) begin
        compare(e.name, "qk", '0, {28'd0, issue_i.qk}, bad);
      end
      if (issue_i.qk == '0) begin
        compare(e.name, "op2", e.op2, issue_i.op2, bad);
      end
      e.bad          = bad;
      pend[disp_ptr] = e;
      disp_ptr++;
    end
  endtask

  task automatic check_retire();
    expect_t e;
    logic    bad;
    logic    exp_flush;
    if (pend.size() == 0) begin
      $display("Retirement seen with no micro-op in flight");
      errors_o++;
    end else begin
      e = pend.pop_front();
      disp_ptr--;
      bad       = e.bad;
      exp_flush = (e.anpc != e.uop.pnpc) || e.uop.trap;
      // Rows retire in table order one pc step apart
      compare(e.name, "retire pc", 32'h100 + 4 * retired_o, retire_i.pc, bad);
      compare(e.name, "retire rd", {27'd0, e.uop.rd}, {27'd0, retire_i.rd}, bad);
      compare(e.name, "wdata", e.result, retire_i.wdata, bad);
      compare(e.name, "npc", e.anpc, retire_i.npc, bad);
      compare(e.name, "flush", {31'd0, exp_flush}, {31'd0, retire_i.flush}, bad);
      compare(e.name, "retire is_store", {31'd0, e.uop.is_store}, {31'd0, retire_i.is_store},
              bad);
      if (e.uop.is_store) begin
        if (!sq_ready_i) begin
          $display("Store %s retired while the store queue was not ready", e.name);
          errors_o++;
          bad = 1'b1;
        end
        compare(e.name, "sq_waddr", e.op1, retire_i.sq_waddr, bad);
        compare(e.name, "sq_wdata", e.op2, retire_i.sq_wdata, bad);
      end
      if (e.uop.rd != '0 && !e.uop.is_store) begin
        arch[e.uop.rd] = e.result;
      end
      if (!bad) begin
        $display("ok   %s", e.name);
        passed_o++;
      end
      retired_o++;
    end
  endtask

  // Sampled mid-cycle so each event lands on the next rising edge
  always @(negedge clock) begin
    if (!rst_n_i) begin
      if (out_valid_i || retire_i.valid || retire_i.flush || !out_ready_i) begin
        $display("Outputs not idle during reset or queue not ready for decode");
        errors_o++;
      end
    end else if (flush_i) begin
      pend.delete();
      disp_ptr = 0;
      for (int i = 0; i < REG_NUM; i++) begin
        spec[i] = arch[i];
      end
    end else begin
      if (out_valid_i && next_ready_i) begin
        check_issue();
      end
      if (retire_i.valid) begin
        check_retire();
      end
      if (prev_valid_i && out_ready_i) begin
        capture_row();
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/rou_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rou_tb;
  import rou_pkg::*;

  localparam int    N_ROWS   = 17;
  localparam int    LIMIT    = 40 * N_ROWS + 200;
  localparam word_t BASE     = 32'h100;
  localparam alu_t  ALU_ADD  = 5'd0;
  localparam alu_t  ALU_PASS = 5'd1;

  typedef struct packed {
    logic [63:0] name;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    word_t       imm1;
    word_t       imm2;
    alu_t        alu;
    logic        st;
    logic        trap;
    word_t       pnpc;
    word_t       anpc;
  } row_t;

  // One micro-op held by the execution model
  typedef struct packed {
    rob_tag_t   dest;
    word_t      op1;
    word_t      op2;
    rob_tag_t   qj;
    rob_tag_t   qk;
    alu_t       alu;
    logic       st;
    word_t      pc;
    logic [2:0] delay;
  } slot_t;

  logic        clock, rst_n, flush, prev_valid, next_ready, sq_ready, out_ready, out_valid;
  rou_uop_t    uop;
  rou_wb_t     wb;
  rou_issue_t  issue;
  rou_retire_t retire;
  word_t       reg_src1, reg_src2, row_anpc;
  reg_idx_t    reg_rs1, reg_rs2;
  logic [63:0] row_name;
  int          errors, passed, retired;

  row_t        tbl [N_ROWS];
  word_t       rf [REG_NUM];
  slot_t       exu_q [$];
  int          n_rows, feed, cycles, seed, rnd;
  logic        cap;
  rou_retire_t ret_s;

  rou_top #(.IQ_SIZE(4), .ROB_SIZE(8)) dut (
    .clock(clock), .rst_n_i(rst_n), .flush_i(flush), .prev_valid_i(prev_valid),
    .uop_i(uop), .next_ready_i(next_ready), .reg_src1_i(reg_src1), .reg_src2_i(reg_src2),
    .wb_i(wb), .sq_ready_i(sq_ready), .out_ready_o(out_ready), .out_valid_o(out_valid),
    .issue_o(issue), .reg_rs1_o(reg_rs1), .reg_rs2_o(reg_rs2), .retire_o(retire)
  );

  rou_checker chk (
    .clock(clock), .rst_n_i(rst_n), .flush_i(flush), .prev_valid_i(prev_valid),
    .out_ready_i(out_ready), .uop_i(uop), .name_i(row_name), .anpc_i(row_anpc),
    .out_valid_i(out_valid), .next_ready_i(next_ready), .issue_i(issue),
    .sq_ready_i(sq_ready), .retire_i(retire),
    .errors_o(errors), .passed_o(passed), .retired_o(retired)
  );

  // Register file model, written at retirement
  assign reg_src1 = rf[reg_rs1];
  assign reg_src2 = rf[reg_rs2];

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic add_row(input logic [63:0] name, input reg_idx_t rd, input reg_idx_t rs1,
                         input reg_idx_t rs2, input word_t imm1, input word_t imm2,
                         input alu_t alu, input logic st, input logic trap,
                         input word_t pnpc, input word_t anpc);
    tbl[n_rows] = {name, rd, rs1, rs2, imm1, imm2, alu, st, trap, pnpc, anpc};
    n_rows++;
  endtask

  task automatic present_row(input int i);
    uop          = '0;
    uop.rd       = tbl[i].rd;
    uop.rs1      = tbl[i].rs1;
    uop.rs2      = tbl[i].rs2;
    uop.imm_op1  = tbl[i].imm1;
    uop.imm_op2  = tbl[i].imm2;
    uop.alu      = tbl[i].alu;
    uop.is_store = tbl[i].st;
    uop.trap     = tbl[i].trap;
    uop.pc       = BASE + 4 * i;
    uop.pnpc     = tbl[i].pnpc;
    row_name     = tbl[i].name;
    row_anpc     = tbl[i].anpc;
  endtask

  task automatic accept_issue(input rou_issue_t is);
    slot_t s;
    s.dest  = is.dest;
    s.op1   = is.op1;
    s.op2   = is.op2;
    s.qj    = is.qj;
    s.qk    = is.qk;
    s.alu   = is.alu;
    s.st    = is.is_store;
    s.pc    = is.pc;
    s.delay = 3'($urandom_range(7, 0));
    exu_q.push_back(s);
  endtask

  task automatic resolve_waits(input rob_tag_t tag, input word_t value);
    slot_t s;
    for (int i = 0; i < exu_q.size(); i++) begin
      s = exu_q[i];
      if (s.qj == tag) begin
        s.qj  = '0;
        s.op1 = value;
      end
      if (s.qk == tag) begin
        s.qk  = '0;
        s.op2 = value;
      end
      exu_q[i] = s;
    end
  endtask

  // Oldest ready slot whose delay ran out goes on the bus
  task automatic send_result();
    slot_t s;
    int    found;
    found = -1;
    for (int i = 0; i < exu_q.size(); i++) begin
      s = exu_q[i];
      if (s.qj == '0 && s.qk == '0) begin
        if (s.delay == '0 && found < 0) begin
          found = i;
        end else if (s.delay != '0) begin
          s.delay--;
          exu_q[i] = s;
        end
      end
    end
    wb = '0;
    if (found >= 0) begin
      s = exu_q[found];
      exu_q.delete(found);
      wb.valid  = 1'b1;
      wb.dest   = s.dest;
      wb.result = (s.alu == ALU_PASS) ? s.op1 : s.op1 + s.op2;
      wb.npc    = tbl[(s.pc - BASE) >> 2].anpc;
      if (s.st) begin
        wb.sq_waddr = s.op1;
        wb.sq_wdata = s.op2;
      end
    end
  endtask

  task automatic sample_cycle();
    cap   = 1'b0;
    ret_s = '0;
    if (!flush) begin
      cap   = prev_valid && out_ready;
      ret_s = retire;
      if (wb.valid) begin
        resolve_waits(wb.dest, wb.result);
      end
      if (out_valid && next_ready) begin
        accept_issue(issue);
      end
    end
  endtask

  task automatic drive_cycle();
    if (ret_s.valid && ret_s.rd != '0 && !ret_s.is_store) begin
      rf[ret_s.rd] = ret_s.wdata;
    end
    flush = ret_s.valid && ret_s.flush;
    if (flush) begin
      // Refetch from the row after the one that flushed
      exu_q.delete();
      feed       = int'((ret_s.pc - BASE) >> 2) + 1;
      prev_valid = 1'b0;
      wb         = '0;
    end else begin
      if (cap) begin
        feed++;
      end
      prev_valid = (feed < N_ROWS);
      if (feed < N_ROWS) begin
        present_row(feed);
      end
      send_result();
    end
    next_ready = ($urandom % 4) != 0;
    sq_ready   = ($urandom % 3) != 0;
  endtask

  initial begin
    seed = 32'ha4c7;
    rnd  = $urandom(seed);
    rst_n      = 1'b0;
    flush      = 1'b0;
    prev_valid = 1'b0;
    next_ready = 1'b0;
    sq_ready   = 1'b0;
    uop        = '0;
    wb         = '0;
    row_name   = '0;
    row_anpc   = '0;
    feed       = 0;
    n_rows     = 0;
    cap        = 1'b0;
    ret_s      = '0;
    for (int i = 0; i < REG_NUM; i++) begin
      rf[i] = i * 32'h0101_0101;
    end
    //      name       rd rs1 rs2 imm1 imm2 alu       st trap pnpc      anpc
    add_row("li_a",     1, 0,  0,  5,   0,   ALU_ADD,  0, 0, 32'h104, 32'h104);
    add_row("li_b",     2, 0,  0,  7,   0,   ALU_ADD,  0, 0, 32'h108, 32'h108);
    add_row("add_ab",   3, 1,  2,  0,   0,   ALU_ADD,  0, 0, 32'h10c, 32'h10c);
    add_row("chain",    3, 3,  1,  0,   0,   ALU_ADD,  0, 0, 32'h110, 32'h110);
    add_row("use_x3",   4, 3,  0,  0,   100, ALU_ADD,  0, 0, 32'h114, 32'h114);
    add_row("wr_x0",    0, 1,  0,  0,   9,   ALU_ADD,  0, 0, 32'h118, 32'h118);
    add_row("rd_x0",    5, 0,  0,  3,   4,   ALU_ADD,  0, 0, 32'h11c, 32'h11c);
    add_row("store",    0, 4,  5,  0,   0,   ALU_ADD,  1, 0, 32'h120, 32'h120);
    add_row("pass",     6, 2,  0,  0,   0,   ALU_PASS, 0, 0, 32'h124, 32'h124);
    add_row("mispred",  7, 6,  0,  0,   1,   ALU_ADD,  0, 0, 32'h128, 32'h200);
    add_row("after_br", 8, 7,  3,  0,   0,   ALU_ADD,  0, 0, 32'h12c, 32'h12c);
    add_row("store2",   0, 8,  1,  0,   0,   ALU_ADD,  1, 0, 32'h130, 32'h130);
    add_row("trap",     0, 0,  0,  0,   0,   ALU_ADD,  0, 1, 32'h134, 32'h134);
    add_row("resume",   9, 8,  10, 0,   0,   ALU_ADD,  0, 0, 32'h138, 32'h138);
    add_row("ovw_a",    10, 9, 0,  0,   1,   ALU_ADD,  0, 0, 32'h13c, 32'h13c);
    add_row("ovw_b",    10, 10, 10, 0,  0,   ALU_ADD,  0, 0, 32'h140, 32'h140);
    add_row("final",    11, 10, 4, 0,   0,   ALU_PASS, 0, 0, 32'h144, 32'h144);
    repeat (16) @(posedge clock);
    #5;
    rst_n = 1'b1;
    while (retired < N_ROWS) begin
      @(negedge clock);
      sample_cycle();
      @(posedge clock);
      #5;
      drive_cycle();
    end
    // Idle a little so a duplicate retirement would still show up
    repeat (8) @(posedge clock);
    $display("%0d tests, %0d passed, %0d errors", N_ROWS, passed, errors);
    if (errors == 0 && passed == N_ROWS) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout after %0d cycles, only %0d of %0d rows retired", cycles, retired, N_ROWS);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire
